/* design/cfu_pkg.sv */
// Matrix row CFU shared definitions

package cfu_pkg;

  // Host port widths
  localparam int DATA_W   = 32;
  localparam int FUNC_W   = 10;
  localparam int FUNCT7_W = 7;

  // Datapath sizes
  localparam int OP_W       = 8;
  localparam int LANES      = 4;
  localparam int ACC_W      = 32;
  localparam int ADDR_W     = 8;
  localparam int DEPTH      = 1 << ADDR_W;
  localparam int LANE_SEL_W = 2;
  localparam int K_W        = 10;

  // funct7 codes, upper bits of function_id
  localparam logic [FUNCT7_W-1:0] FUNC_WRITE_A = 7'd1;
  localparam logic [FUNCT7_W-1:0] FUNC_WRITE_B = 7'd2;
  localparam logic [FUNCT7_W-1:0] FUNC_COMPUTE = 7'd3;
  localparam logic [FUNCT7_W-1:0] FUNC_READ    = 7'd4;

  // Buffer read, three skew stages, accumulate
  localparam int DRAIN_CYCLES = 5;

  // Controller state encoding
  localparam int STATE_W = 3;
  localparam logic [STATE_W-1:0] ST_IDLE    = 3'd0;
  localparam logic [STATE_W-1:0] ST_WRITE_A = 3'd1;
  localparam logic [STATE_W-1:0] ST_WRITE_B = 3'd2;
  localparam logic [STATE_W-1:0] ST_READ    = 3'd3;
  localparam logic [STATE_W-1:0] ST_CLEAR   = 3'd4;
  localparam logic [STATE_W-1:0] ST_FEED    = 3'd5;
  localparam logic [STATE_W-1:0] ST_DRAIN   = 3'd6;
  localparam logic [STATE_W-1:0] ST_FINISH  = 3'd7;

  // One B word, stored whole and consumed per lane
  // Lane 0 sits in the top byte
  typedef union packed {
    logic [DATA_W-1:0]           word;
    logic [0:LANES-1][OP_W-1:0]  lanes;
  } b_word_u;

endpackage

/* design/a_operand_feed.sv */
// A operand buffer and feed

`timescale 1ns/1ps

module a_operand_feed (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            a_wr_en,
  input  logic [cfu_pkg::ADDR_W-1:0]      wr_addr,
  input  logic [cfu_pkg::DATA_W-1:0]      wr_data,
  input  logic                            feed_en,
  input  logic [cfu_pkg::ADDR_W-1:0]      feed_index,
  output logic signed [cfu_pkg::OP_W-1:0] a_operand
);

  logic [cfu_pkg::OP_W-1:0] a_mem [0:cfu_pkg::DEPTH-1];

  // Host data sits in the top byte of inputs_1
  always_ff @(posedge clk) begin
    if (a_wr_en) begin
      a_mem[wr_addr] <= wr_data[cfu_pkg::DATA_W-1 -: cfu_pkg::OP_W];
    end
  end

  // Registered read, zero when no feed is running
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_operand <= '0;
    end else if (feed_en) begin
      a_operand <= a_mem[feed_index];
    end else begin
      a_operand <= '0;
    end
  end

endmodule

/* design/b_operand_feed.sv */
// B operand buffer with lane skew

`timescale 1ns/1ps

module b_operand_feed (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       b_wr_en,
  input  logic [cfu_pkg::ADDR_W-1:0] wr_addr,
  input  logic [cfu_pkg::DATA_W-1:0] wr_data,
  input  logic                       feed_en,
  input  logic [cfu_pkg::ADDR_W-1:0] feed_index,
  output cfu_pkg::b_word_u           b_lanes
);

  logic [cfu_pkg::DATA_W-1:0] b_mem [0:cfu_pkg::DEPTH-1];
  cfu_pkg::b_word_u           rd_q;
  logic [cfu_pkg::OP_W-1:0]   skewed [0:cfu_pkg::LANES-1];

  always_ff @(posedge clk) begin
    if (b_wr_en) begin
      b_mem[wr_addr] <= wr_data;
    end
  end

  // Whole word read, gated to zero outside the feed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_q.word <= '0;
    end else if (feed_en) begin
      rd_q.word <= b_mem[feed_index];
    end else begin
      rd_q.word <= '0;
    end
  end

  // Lane 0 meets the A operand at cell 0 right away
  assign skewed[0] = rd_q.lanes[0];

  // Lane j waits j more cycles, matching the A hops east
  for (genvar j = 1; j < cfu_pkg::LANES; j++) begin : g_skew
    logic [cfu_pkg::OP_W-1:0] pipe_q [0:j-1];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        for (int s = 0; s < j; s++) begin
          pipe_q[s] <= '0;
        end
      end else begin
        pipe_q[0] <= rd_q.lanes[j];
        for (int s = 1; s < j; s++) begin
          pipe_q[s] <= pipe_q[s-1];
        end
      end
    end

    assign skewed[j] = pipe_q[j-1];
  end

  always_comb begin
    for (int j = 0; j < cfu_pkg::LANES; j++) begin
      b_lanes.lanes[j] = skewed[j];
    end
  end

endmodule

/* design/mac_row.sv */
// Systolic MAC row

`timescale 1ns/1ps

module mac_row (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            acc_clear,
  input  logic signed [cfu_pkg::OP_W-1:0] a_operand,
  input  cfu_pkg::b_word_u                b_lanes,
  input  logic [cfu_pkg::LANE_SEL_W-1:0]  lane_sel,
  output logic [cfu_pkg::ACC_W-1:0]       lane_result
);

  // A operand as seen by each cell, travelling east
  logic signed [cfu_pkg::OP_W-1:0] a_west [0:cfu_pkg::LANES-1];
  logic [cfu_pkg::ACC_W-1:0]       acc_row [0:cfu_pkg::LANES-1];

  assign a_west[0] = a_operand;

  for (genvar j = 0; j < cfu_pkg::LANES; j++) begin : g_cell
    logic signed [2*cfu_pkg::OP_W-1:0] prod;
    logic signed [cfu_pkg::ACC_W-1:0]  acc_q;

    assign prod = a_west[j] * $signed(b_lanes.lanes[j]);

    // Accumulator wraps at 32 bits
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        acc_q <= '0;
      end else if (acc_clear) begin
        acc_q <= '0;
      end else begin
        acc_q <= acc_q + cfu_pkg::ACC_W'(prod);
      end
    end

    assign acc_row[j] = acc_q;

    // Pass A to the next cell, last cell has no neighbour
    if (j < cfu_pkg::LANES - 1) begin : g_east
      logic signed [cfu_pkg::OP_W-1:0] a_east_q;

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          a_east_q <= '0;
        end else begin
          a_east_q <= a_west[j];
        end
      end

      assign a_west[j+1] = a_east_q;
    end
  end

  // Read-back select
  assign lane_result = acc_row[lane_sel];

endmodule

/* design/cfu_cmd_ctrl.sv */
// CFU command controller

`timescale 1ns/1ps

module cfu_cmd_ctrl (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            cmd_valid,
  input  logic [cfu_pkg::FUNC_W-1:0]      function_id,
  input  logic [cfu_pkg::DATA_W-1:0]      inputs_0,
  input  logic [cfu_pkg::DATA_W-1:0]      inputs_1,
  output logic                            cmd_ready,
  output logic                            rsp_valid,
  output logic                            a_wr_en,
  output logic                            b_wr_en,
  output logic [cfu_pkg::ADDR_W-1:0]      wr_addr,
  output logic [cfu_pkg::DATA_W-1:0]      wr_data,
  output logic                            feed_en,
  output logic [cfu_pkg::ADDR_W-1:0]      feed_index,
  output logic                            acc_clear,
  output logic [cfu_pkg::LANE_SEL_W-1:0]  lane_sel
);

  logic [cfu_pkg::STATE_W-1:0]  state_q;
  logic [cfu_pkg::STATE_W-1:0]  state_d;
  logic [cfu_pkg::FUNCT7_W-1:0] funct7;
  logic [cfu_pkg::DATA_W-1:0]   op0_q;
  logic [cfu_pkg::DATA_W-1:0]   op1_q;
  logic [cfu_pkg::K_W-1:0]      k_len;
  logic [cfu_pkg::K_W-1:0]      cnt_q;
  logic                         accept;
  logic                         cnt_last;

  assign funct7 = function_id[cfu_pkg::FUNC_W-1 -: cfu_pkg::FUNCT7_W];
  assign accept = (state_q == cfu_pkg::ST_IDLE) && cmd_valid;
  assign k_len  = op0_q[cfu_pkg::K_W-1:0];

  // Both operand words held for the whole command
  always_ff @(posedge clk) begin
    if (accept) begin
      op0_q <= inputs_0;
      op1_q <= inputs_1;
    end
  end

  // Last feed cycle at K-1, last drain cycle at DRAIN_CYCLES-1
  always_comb begin
    cnt_last = 1'b0;
    if (state_q == cfu_pkg::ST_FEED) begin
      cnt_last = (cnt_q == k_len - cfu_pkg::K_W'(1));
    end else if (state_q == cfu_pkg::ST_DRAIN) begin
      cnt_last = (cnt_q == cfu_pkg::K_W'(cfu_pkg::DRAIN_CYCLES - 1));
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      cfu_pkg::ST_IDLE: begin
        if (cmd_valid) begin
          case (funct7)
            cfu_pkg::FUNC_WRITE_A: state_d = cfu_pkg::ST_WRITE_A;
            cfu_pkg::FUNC_WRITE_B: state_d = cfu_pkg::ST_WRITE_B;
            cfu_pkg::FUNC_COMPUTE: state_d = cfu_pkg::ST_CLEAR;
            cfu_pkg::FUNC_READ:    state_d = cfu_pkg::ST_READ;
            // Unknown ids are dropped
            default:               state_d = cfu_pkg::ST_IDLE;
          endcase
        end
      end
      cfu_pkg::ST_WRITE_A: state_d = cfu_pkg::ST_FINISH;
      cfu_pkg::ST_WRITE_B: state_d = cfu_pkg::ST_FINISH;
      cfu_pkg::ST_READ:    state_d = cfu_pkg::ST_FINISH;
      cfu_pkg::ST_CLEAR:   state_d = cfu_pkg::ST_FEED;
      cfu_pkg::ST_FEED:    state_d = cnt_last ? cfu_pkg::ST_DRAIN : cfu_pkg::ST_FEED;
      cfu_pkg::ST_DRAIN:   state_d = cnt_last ? cfu_pkg::ST_FINISH : cfu_pkg::ST_DRAIN;
      default:             state_d = cfu_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= cfu_pkg::ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // Shared counter, restarts at each phase boundary
      if ((state_q == cfu_pkg::ST_FEED || state_q == cfu_pkg::ST_DRAIN) && !cnt_last) begin
        cnt_q <= cnt_q + cfu_pkg::K_W'(1);
      end else begin
        cnt_q <= '0;
      end
    end
  end

  assign a_wr_en    = (state_q == cfu_pkg::ST_WRITE_A);
  assign b_wr_en    = (state_q == cfu_pkg::ST_WRITE_B);
  assign acc_clear  = (state_q == cfu_pkg::ST_CLEAR);
  assign feed_en    = (state_q == cfu_pkg::ST_FEED);
  assign feed_index = cnt_q[cfu_pkg::ADDR_W-1:0];
  assign wr_addr    = op0_q[cfu_pkg::ADDR_W-1:0];
  assign wr_data    = op1_q;
  assign lane_sel   = op1_q[cfu_pkg::LANE_SEL_W-1:0];

  // Ready and valid are one and the same pulse
  assign rsp_valid = (state_q == cfu_pkg::ST_FINISH);
  assign cmd_ready = rsp_valid;

endmodule

/* design/cfu_top.sv */
// Matrix row CFU top level

`timescale 1ns/1ps

module cfu_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cmd_valid,
  input  logic [cfu_pkg::FUNC_W-1:0]  function_id,
  input  logic [cfu_pkg::DATA_W-1:0]  inputs_0,
  input  logic [cfu_pkg::DATA_W-1:0]  inputs_1,
  input  logic                        rsp_ready,
  output logic                        cmd_ready,
  output logic                        rsp_valid,
  output logic [cfu_pkg::DATA_W-1:0]  rsp_payload
);

  // rsp_ready has no effect, the response is a fixed one-cycle pulse
  logic                            a_wr_en;
  logic                            b_wr_en;
  logic [cfu_pkg::ADDR_W-1:0]      wr_addr;
  logic [cfu_pkg::DATA_W-1:0]      wr_data;
  logic                            feed_en;
  logic [cfu_pkg::ADDR_W-1:0]      feed_index;
  logic                            acc_clear;
  logic [cfu_pkg::LANE_SEL_W-1:0]  lane_sel;
  logic signed [cfu_pkg::OP_W-1:0] a_operand;
  cfu_pkg::b_word_u                b_lanes;
  logic [cfu_pkg::ACC_W-1:0]       lane_result;

  cfu_cmd_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .function_id (function_id),
    .inputs_0    (inputs_0),
    .inputs_1    (inputs_1),
    .cmd_ready   (cmd_ready),
    .rsp_valid   (rsp_valid),
    .a_wr_en     (a_wr_en),
    .b_wr_en     (b_wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .feed_en     (feed_en),
    .feed_index  (feed_index),
    .acc_clear   (acc_clear),
    .lane_sel    (lane_sel)
  );

  a_operand_feed u_a_feed (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_wr_en    (a_wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .feed_en    (feed_en),
    .feed_index (feed_index),
    .a_operand  (a_operand)
  );

  b_operand_feed u_b_feed (
    .clk        (clk),
    .rst_n      (rst_n),
    .b_wr_en    (b_wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .feed_en    (feed_en),
    .feed_index (feed_index),
    .b_lanes    (b_lanes)
  );

  mac_row u_mac_row (
    .clk         (clk),
    .rst_n       (rst_n),
    .acc_clear   (acc_clear),
    .a_operand   (a_operand),
    .b_lanes     (b_lanes),
    .lane_sel    (lane_sel),
    .lane_result (lane_result)
  );

  assign rsp_payload = lane_result;

endmodule

/* test/cfu_assertions.sv */
// Controller protocol assertions

`timescale 1ns/1ps

module cfu_assertions (
  input logic clk,
  input logic rst_n,
  input logic cmd_ready,
  input logic rsp_valid,
  input logic a_wr_en,
  input logic b_wr_en,
  input logic feed_en
);

  // Failures seen so far, read by the testbench at the end
  int fail_count = 0;

  // A write strobe is answered by the ready and valid pulse one cycle later
  write_then_response: assert property (@(posedge clk) disable iff (!rst_n)
    (a_wr_en || b_wr_en) |=> (rsp_valid && cmd_ready))
    else begin
      $error("Write strobe was not followed by the response pulse");
      fail_count++;
    end

  // Response is a single-cycle pulse
  single_cycle_response: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |=> !rsp_valid)
    else begin
      $error("rsp_valid held for more than one cycle");
      fail_count++;
    end

  exclusive_strobes: assert property (@(posedge clk) disable iff (!rst_n)
    !(a_wr_en && b_wr_en) && !((a_wr_en || b_wr_en) && feed_en))
    else begin
      $error("Write strobes overlap each other or the feed");
      fail_count++;
    end

endmodule

/* test/cfu_checker.sv */
// CFU response checker

`timescale 1ns/1ps

module cfu_checker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  logic [cfu_pkg::FUNC_W-1:0] function_id,
  input  logic                       rsp_valid,
  input  logic [cfu_pkg::DATA_W-1:0] rsp_payload,
  input  logic [cfu_pkg::DATA_W-1:0] exp_value,
  input  logic                       exp_is_read,
  output int                         value_errors,
  output int                         protocol_errors,
  output int                         responses
);

  // Writes and reads answer on the second edge after acceptance
  localparam int FIXED_LATENCY = 2;

  logic [cfu_pkg::FUNCT7_W-1:0] funct7;
  logic                         pending;
  logic                         pend_read;
  logic                         pend_fixed;
  logic [cfu_pkg::DATA_W-1:0]   pend_value;
  int                           wait_cycles;

  assign funct7 = function_id[cfu_pkg::FUNC_W-1 -: cfu_pkg::FUNCT7_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending         <= 1'b0;
      pend_read       <= 1'b0;
      pend_fixed      <= 1'b0;
      pend_value      <= '0;
      wait_cycles     <= 0;
      value_errors    <= 0;
      protocol_errors <= 0;
      responses       <= 0;
    end else if (pending) begin
      if (rsp_valid) begin
        pending   <= 1'b0;
        responses <= responses + 1;
        if (pend_read && rsp_payload !== pend_value) begin
          $display("FAILED rsp_payload expected %08h got %08h", pend_value, rsp_payload);
          value_errors <= value_errors + 1;
        end
        if (pend_fixed && wait_cycles != FIXED_LATENCY) begin
          $display("Response came %0d cycles after acceptance, expected %0d",
                   wait_cycles, FIXED_LATENCY);
          protocol_errors <= protocol_errors + 1;
        end
      end else begin
        wait_cycles <= wait_cycles + 1;
      end
    end else if (rsp_valid) begin
      $display("Response pulse seen with no command outstanding");
      protocol_errors <= protocol_errors + 1;
    end else if (cmd_valid) begin
      // Controller is idle here, so this edge accepts the command
      pending     <= 1'b1;
      pend_read   <= exp_is_read;
      pend_fixed  <= (funct7 != cfu_pkg::FUNC_COMPUTE);
      pend_value  <= exp_value;
      wait_cycles <= 1;
    end
  end

endmodule

/* test/tb_top.sv */
// CFU testbench

`timescale 1ns/1ps

module tb_top;

  localparam int MAX_CASES    = 64;
  localparam int COLS         = 4;
  localparam int CYCLE_BUDGET = 256 + 20;
  localparam int SETTLE       = 2;
  localparam logic [31:0] END_MARK = 32'hFFFF_FFFF;

  logic                       clk;
  logic                       rst_n;
  logic                       cmd_valid;
  logic [cfu_pkg::FUNC_W-1:0] function_id;
  logic [cfu_pkg::DATA_W-1:0] inputs_0;
  logic [cfu_pkg::DATA_W-1:0] inputs_1;
  logic                       rsp_ready;
  logic                       cmd_ready;
  logic                       rsp_valid;
  logic [cfu_pkg::DATA_W-1:0] rsp_payload;
  logic [cfu_pkg::DATA_W-1:0] exp_value;
  logic                       exp_is_read;

  // Four words per case: funct7, inputs_0, inputs_1, expected
  logic [31:0] case_mem [0:MAX_CASES*COLS-1];
  int          num_cases;
  int          cycle_count;
  int          cycle_limit;
  int          value_errors;
  int          protocol_errors;
  int          responses;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  bind cfu_cmd_ctrl cfu_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .a_wr_en   (a_wr_en),
    .b_wr_en   (b_wr_en),
    .feed_en   (feed_en)
  );

  cfu_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .function_id (function_id),
    .inputs_0    (inputs_0),
    .inputs_1    (inputs_1),
    .rsp_ready   (rsp_ready),
    .cmd_ready   (cmd_ready),
    .rsp_valid   (rsp_valid),
    .rsp_payload (rsp_payload)
  );

  cfu_checker u_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .function_id     (function_id),
    .rsp_valid       (rsp_valid),
    .rsp_payload     (rsp_payload),
    .exp_value       (exp_value),
    .exp_is_read     (exp_is_read),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors),
    .responses       (responses)
  );

  task automatic load_cases();
    for (int i = 0; i < MAX_CASES*COLS; i++) begin
      case_mem[i] = END_MARK;
    end
    $readmemh("test/cfu_cases.txt", case_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && case_mem[num_cases*COLS] != END_MARK) begin
      num_cases++;
    end
    cycle_limit = num_cases * CYCLE_BUDGET;
  endtask

  // Drive on the falling edge, hold until the response pulse
  task automatic send_command(input int idx);
    logic [31:0] funct7_word;
    funct7_word = case_mem[idx*COLS];
    @(negedge clk);
    // funct3 bits stay zero
    function_id = {funct7_word[cfu_pkg::FUNCT7_W-1:0], 3'b000};
    inputs_0    = case_mem[idx*COLS+1];
    inputs_1    = case_mem[idx*COLS+2];
    exp_value   = case_mem[idx*COLS+3];
    exp_is_read = (funct7_word[cfu_pkg::FUNCT7_W-1:0] == cfu_pkg::FUNC_READ);
    cmd_valid   = 1'b1;
    do begin
      @(negedge clk);
    end while (!cmd_ready);
    cmd_valid = 1'b0;
  endtask

  task automatic finish_run(input logic timed_out);
    int assert_errors;
    int count_errors;
    int total;
    assert_errors = dut.u_ctrl.u_assertions.fail_count;
    count_errors  = 0;
    if (num_cases == 0) begin
      $display("No cases were read from the case file");
      count_errors = 1;
    end else if (!timed_out && responses != num_cases) begin
      $display("Got %0d responses for %0d commands", responses, num_cases);
      count_errors = 1;
    end
    total = value_errors + protocol_errors + assert_errors + count_errors + int'(timed_out);
    $display("Errors: value %0d, protocol %0d, assertion %0d, count %0d, timeout %0d",
             value_errors, protocol_errors, assert_errors, count_errors, int'(timed_out));
    if (total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  initial begin
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    function_id = '0;
    inputs_0    = '0;
    inputs_1    = '0;
    rsp_ready   = 1'b1;
    exp_value   = '0;
    exp_is_read = 1'b0;
    load_cases();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < num_cases; i++) begin
      send_command(i);
    end
    repeat (SETTLE) @(negedge clk);
    finish_run(1'b0);
  end

  // Cycle limit scales with the number of cases
  initial begin
    cycle_count = 0;
    #1;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles with a command still open", cycle_count);
    finish_run(1'b1);
  end

endmodule

/* test/cfu_cases.txt */
// funct7 inputs_0 inputs_1 expected, all hex, one command per line
// expected is compared on read lines (funct7 04) only
04 00000000 00000000 00000000
04 00000000 00000001 00000000
04 00000000 00000002 00000000
04 00000000 00000003 00000000
01 00000000 FD000000 00000000
02 00000000 05FE7F80 00000000
03 00000001 00000000 00000000
04 00000000 00000000 FFFFFFF1
04 00000000 00000001 00000006
04 00000000 00000002 FFFFFE83
04 00000000 00000003 00000180
01 00000001 07000000 00000000
01 00000002 80000000 00000000
01 00000003 64000000 00000000
02 00000001 01020304 00000000
02 00000002 FF10807F 00000000
02 00000003 9C00C80A 00000000
03 00000004 00000000 00000000
04 00000000 00000000 FFFFD968
04 00000000 00000001 FFFFF814
04 00000000 00000002 000028B8
04 00000000 00000003 FFFFC604
03 00000002 00000000 00000000
04 00000000 00000000 FFFFFFF8
04 00000000 00000001 00000014
04 00000000 00000002 FFFFFE98
04 00000000 00000003 0000019C

/* tb.f */
design/cfu_pkg.sv
design/a_operand_feed.sv
design/b_operand_feed.sv
design/mac_row.sv
design/cfu_cmd_ctrl.sv
design/cfu_top.sv
test/cfu_assertions.sv
test/cfu_checker.sv
test/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CFU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_top +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
